// File: source/ising_energy_pkg.sv
`default_nettype none

package ising_energy_pkg;

    // ========================================
    // Sizing
    // ========================================
    localparam int NUM_SPINS    = 16;                         // Spins in the machine
    localparam int BIT_J        = 4;                          // Coupling weight width
    localparam int BIT_H        = 4;                          // Local field width
    localparam int SCALING_BIT  = 5;                          // Field scaling code width
    localparam int MULT_BIT     = BIT_H + SCALING_BIT - 1;    // One signed product
    localparam int ENERGY_BIT   = 16;                         // One partial energy
    localparam int SPIN_IDX_BIT = $clog2(NUM_SPINS);          // Spin index width
    localparam int TOTAL_BIT    = ENERGY_BIT + SPIN_IDX_BIT;  // Room for NUM_SPINS partials
    localparam int ROW_BIT      = NUM_SPINS * BIT_J;          // One packed J row

    // ========================================
    // Vector types
    // ========================================
    // Bit k set means sigma_k = +1, clear means -1
    typedef logic [NUM_SPINS-1:0] spin_vec_t;
    typedef logic [SPIN_IDX_BIT-1:0] spin_idx_t;

    // Weight j of a row sits at bits [j*BIT_J +: BIT_J], two's complement
    typedef logic [ROW_BIT-1:0] weight_row_t;

    typedef logic signed [BIT_H-1:0] hbias_t;
    typedef logic [SCALING_BIT-1:0] hscale_t;           // 1, 2, 4, 8 or 16, else treated as 1
    typedef logic signed [MULT_BIT-1:0] product_t;
    typedef logic signed [ENERGY_BIT-1:0] energy_t;
    typedef logic signed [TOTAL_BIT-1:0] total_energy_t;

    // ========================================
    // Sequencer states
    // ========================================
    typedef enum logic [1:0] {
        SEQ_IDLE, // Waiting for start
        SEQ_RUN,  // One spin per cycle
        SEQ_DONE  // Total valid, done pulse
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/partial_energy_if.sv
`default_nettype none

// Operands and result of one spin's energy evaluation
interface partial_energy_if;
    import ising_energy_pkg::*;

    spin_vec_t   spin;       // Captured spin vector
    spin_vec_t   spin_mask;  // One-hot, spin under evaluation
    weight_row_t weight;     // J row of the masked spin
    hbias_t      hbias;      // h of the masked spin
    hscale_t     hscaling;   // Field scaling code
    energy_t     energy;     // Partial energy result

    // Sequencer side sets up the operands
    modport seq (
        output spin, spin_mask, weight, hbias, hscaling,
        input  energy
    );

    // Calculator side, pure combinational
    modport calc (
        input  spin, spin_mask, weight, hbias, hscaling,
        output energy
    );

endinterface

`default_nettype wire

// File: source/adder_tree.sv
`default_nettype none

// Recursive signed adder tree
// Each leaf is sign extended to energy_t, so partial sums never wrap
// as long as DATAW + clog2(N) fits in ENERGY_BIT
module adder_tree #(
    parameter int N     = 16,
    parameter int DATAW = 8
) (
    input  logic [N-1:0][DATAW-1:0]  data_i,  // Signed operands, packed
    output ising_energy_pkg::energy_t sum_o    // Signed sum
);
    import ising_energy_pkg::*;

    generate
        if (N == 1) begin : g_leaf
            // Single element, just widen
            assign sum_o = energy_t'(signed'(data_i[0]));

        end else begin : g_split
            localparam int NLO = N / 2;      // Lower half, the smaller one when N is odd
            localparam int NHI = N - NLO;    // Upper half

            energy_t sum_lo;  // Sum of lower half
            energy_t sum_hi;  // Sum of upper half

            adder_tree #(
                .N     (NLO),
                .DATAW (DATAW)
            ) u_lo (
                .data_i (data_i[NLO-1:0]),
                .sum_o  (sum_lo)
            );

            adder_tree #(
                .N     (NHI),
                .DATAW (DATAW)
            ) u_hi (
                .data_i (data_i[N-1:NLO]),
                .sum_o  (sum_hi)
            );

            assign sum_o = sum_lo + sum_hi;  // Both halves already signed
        end
    endgenerate

endmodule

`default_nettype wire

// File: source/partial_energy_calc.sv
`default_nettype none

// Energy of the masked spin k against its row and field
//   E_k = sigma_k * (h_k * scale + sum_{j != k} sigma_j * J_kj)
module partial_energy_calc (
    partial_energy_if.calc pe
);
    import ising_energy_pkg::*;

    product_t                          weight_ext [NUM_SPINS];  // Sign extended weights
    logic [NUM_SPINS-1:0][MULT_BIT-1:0] mult_out;               // Tree operands
    logic [2:0]                        hshift;                   // log2 of scaling code
    product_t                          hbias_scaled;             // h_k * scale
    logic                              masked_bit;               // Spin value of k
    energy_t                           tree_sum;                 // Field plus couplings

    // ========================================
    // Unpack row
    // ========================================
    always_comb begin
        for (int i = 0; i < NUM_SPINS; i++) begin
            weight_ext[i] = product_t'(signed'(pe.weight[i*BIT_J +: BIT_J]));
        end
    end

    // Mask is one-hot, so the AND leaves at most one bit
    assign masked_bit = |(pe.spin & pe.spin_mask);

    // ========================================
    // Field scaling
    // ========================================
    always_comb begin
        case (pe.hscaling)
            'd1:     hshift = 3'd0;
            'd2:     hshift = 3'd1;
            'd4:     hshift = 3'd2;
            'd8:     hshift = 3'd3;
            'd16:    hshift = 3'd4;
            default: hshift = 3'd0;  // Zero and non powers of two act as 1
        endcase
    end

    // -8 * 16 = -128 still fits in product_t
    assign hbias_scaled = product_t'(pe.hbias) <<< hshift;

    // ========================================
    // Products
    // ========================================
    always_comb begin
        for (int i = 0; i < NUM_SPINS; i++) begin
            if (pe.spin_mask[i]) begin
                mult_out[i] = hbias_scaled;         // Field in place of J_kk
            end else if (pe.spin[i]) begin
                mult_out[i] = weight_ext[i];        // sigma_j = +1
            end else begin
                mult_out[i] = -weight_ext[i];       // sigma_j = -1
            end
        end
    end

    // ========================================
    // Sum and spin sign
    // ========================================
    adder_tree #(
        .N     (NUM_SPINS),
        .DATAW (MULT_BIT)
    ) u_adder_tree (
        .data_i (mult_out),
        .sum_o  (tree_sum)
    );

    assign pe.energy = masked_bit ? tree_sum : -tree_sum;

    // Sequencer must never select two spins at once
    always_comb begin
        assert ($onehot0(pe.spin_mask))
            else $error("partial_energy_calc: spin mask has several bits set");
    end

endmodule

`default_nettype wire

// File: source/coupling_mem.sv
`default_nettype none

// J rows and h values in flops
// Synchronous write, combinational read
module coupling_mem (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          wr_en_i,     // Write strobe, level
    input  ising_energy_pkg::spin_idx_t   wr_idx_i,    // Spin being written
    input  ising_energy_pkg::weight_row_t wr_row_i,    // New J row
    input  ising_energy_pkg::hbias_t      wr_hbias_i,  // New h
    input  ising_energy_pkg::spin_idx_t   rd_idx_i,    // Spin being read
    output ising_energy_pkg::weight_row_t rd_row_o,
    output ising_energy_pkg::hbias_t      rd_hbias_o
);
    import ising_energy_pkg::*;

    weight_row_t row_q   [NUM_SPINS];  // One J row per spin
    hbias_t      hbias_q [NUM_SPINS];  // One h per spin

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_SPINS; i++) begin
                row_q[i]   <= '0;
                hbias_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            row_q[wr_idx_i]   <= wr_row_i;
            hbias_q[wr_idx_i] <= wr_hbias_i;
        end
    end

    // ========================================
    // Read port
    // ========================================
    // Visible the cycle after the write edge
    assign rd_row_o   = row_q[rd_idx_i];
    assign rd_hbias_o = hbias_q[rd_idx_i];

    // An X index would corrupt an unknown row
    a_wr_idx_known : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wr_en_i |-> !$isunknown(wr_idx_i)
    ) else $error("coupling_mem: write with unknown index");

endmodule

`default_nettype wire

// File: source/energy_sequencer.sv
`default_nettype none

// Walks spins 0..15, one per cycle, and sums the partial energies
module energy_sequencer (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            start_i,     // Pulse, ignored while busy
    input  ising_energy_pkg::spin_vec_t     spin_i,      // Spin vector to evaluate
    input  ising_energy_pkg::hscale_t       hscaling_i,  // Field scaling code
    output ising_energy_pkg::spin_idx_t     rd_idx_o,    // Memory read index
    input  ising_energy_pkg::weight_row_t   rd_row_i,
    input  ising_energy_pkg::hbias_t        rd_hbias_i,
    partial_energy_if.seq                   pe,          // To the calculator
    output logic                            busy_o,
    output logic                            done_o,      // One cycle pulse
    output ising_energy_pkg::total_energy_t energy_o     // Held until next completion
);
    import ising_energy_pkg::*;

    localparam spin_idx_t LAST_IDX = spin_idx_t'(NUM_SPINS - 1);

    seq_state_t    state_q;
    spin_idx_t     idx_q;       // Current spin
    spin_vec_t     spin_q;      // Captured at start
    hscale_t       hscale_q;    // Captured at start
    total_energy_t acc_q;       // Running sum
    total_energy_t acc_next;
    total_energy_t energy_ext;  // Partial energy widened
    total_energy_t energy_q;    // Published total
    logic          start_ok;    // Start accepted this edge

    assign busy_o   = (state_q == SEQ_RUN);
    assign done_o   = (state_q == SEQ_DONE);
    assign energy_o = energy_q;
    assign start_ok = start_i && !busy_o;

    // ========================================
    // Operands to calculator
    // ========================================
    assign rd_idx_o     = idx_q;
    assign pe.spin      = spin_q;
    assign pe.spin_mask = spin_vec_t'(1) << idx_q;  // One-hot at current index
    assign pe.weight    = rd_row_i;                 // Straight from memory read
    assign pe.hbias     = rd_hbias_i;
    assign pe.hscaling  = hscale_q;

    assign energy_ext = {{(TOTAL_BIT-ENERGY_BIT){pe.energy[ENERGY_BIT-1]}}, pe.energy};
    assign acc_next   = acc_q + energy_ext;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= SEQ_IDLE;
            idx_q    <= '0;
            energy_q <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE, SEQ_DONE: begin
                    // Back to back start allowed from DONE
                    if (start_i) begin
                        state_q <= SEQ_RUN;
                        idx_q   <= '0;
                    end else begin
                        state_q <= SEQ_IDLE;
                    end
                end
                SEQ_RUN: begin
                    idx_q <= idx_q + spin_idx_t'(1);
                    if (idx_q == LAST_IDX) begin
                        state_q  <= SEQ_DONE;
                        energy_q <= acc_next;  // Includes last spin
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // Operand capture and accumulator
    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            spin_q   <= spin_i;
            hscale_q <= hscaling_i;
            acc_q    <= '0;
        end else if (busy_o) begin
            acc_q <= acc_next;
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_done_pulse : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        done_o |=> !done_o
    ) else $error("energy_sequencer: done held longer than one cycle");

    a_busy_done_excl : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(busy_o && done_o)
    ) else $error("energy_sequencer: busy and done high together");

endmodule

`default_nettype wire

// File: source/ising_energy_top.sv
`default_nettype none

// Ising energy evaluator, 16 spins
module ising_energy_top (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Coupling load
    input  logic                            wr_en_i,
    input  ising_energy_pkg::spin_idx_t     wr_idx_i,
    input  ising_energy_pkg::weight_row_t   wr_row_i,
    input  ising_energy_pkg::hbias_t        wr_hbias_i,
    // Evaluation
    input  logic                            start_i,
    input  ising_energy_pkg::spin_vec_t     spin_i,
    input  ising_energy_pkg::hscale_t       hscaling_i,
    output logic                            busy_o,
    output logic                            done_o,
    output ising_energy_pkg::total_energy_t energy_o
);
    import ising_energy_pkg::*;

    spin_idx_t   rd_idx;    // Sequencer to memory
    weight_row_t rd_row;    // Memory to sequencer
    hbias_t      rd_hbias;

    partial_energy_if pe_if ();

    coupling_mem u_coupling_mem (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_idx_i   (wr_idx_i),
        .wr_row_i   (wr_row_i),
        .wr_hbias_i (wr_hbias_i),
        .rd_idx_i   (rd_idx),
        .rd_row_o   (rd_row),
        .rd_hbias_o (rd_hbias)
    );

    energy_sequencer u_energy_sequencer (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .start_i    (start_i),
        .spin_i     (spin_i),
        .hscaling_i (hscaling_i),
        .rd_idx_o   (rd_idx),
        .rd_row_i   (rd_row),
        .rd_hbias_i (rd_hbias),
        .pe         (pe_if.seq),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .energy_o   (energy_o)
    );

    partial_energy_calc u_partial_energy_calc (
        .pe (pe_if.calc)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none

// Free running clock and power-on reset for the testbench
module tb_clock_gen (
    output logic clk_o,     // 10 ns period
    output logic arst_n_o   // Low for the first cycles
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;                       // Asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;                       // Released away from the rising edge
    end

endmodule

`default_nettype wire

// File: tests/tb_ising_energy.sv
`default_nettype none

// Testbench for the 16 spin energy evaluator
module tb_ising_energy;
    timeunit 1ns;
    timeprecision 100ps;
    import ising_energy_pkg::*;

    localparam int RAND_EVALS   = 30;
    localparam int NUM_EVALS    = RAND_EVALS + 4;         // Tests 1, 2, 4, 5 run once
    localparam int LOAD_CYCLES  = 2 * NUM_SPINS + 1 + 8;  // Two loads, one rewrite, reset
    localparam int MAX_CYCLES   = 40 * NUM_EVALS + LOAD_CYCLES;
    localparam int DONE_LATENCY = NUM_SPINS;              // Edges from start to done

    logic          clk;
    logic          arst_n;
    logic          wr_en;
    spin_idx_t     wr_idx;
    weight_row_t   wr_row;
    hbias_t        wr_hbias;
    logic          start;
    spin_vec_t     spin;
    hscale_t       hscaling;
    logic          busy;
    logic          done;
    total_energy_t energy;

    weight_row_t model_row [NUM_SPINS];  // Shadow of every row written
    hbias_t      model_h   [NUM_SPINS];  // Shadow of every field written
    integer      seed;
    int          cycle_cnt  = 0;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ising_energy_top uut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .wr_en_i    (wr_en),
        .wr_idx_i   (wr_idx),
        .wr_row_i   (wr_row),
        .wr_hbias_i (wr_hbias),
        .start_i    (start),
        .spin_i     (spin),
        .hscaling_i (hscaling),
        .busy_o     (busy),
        .done_o     (done),
        .energy_o   (energy)
    );

    // ========================================
    // Reporting
    // ========================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_energy(input string name, input total_energy_t exp,
                                input total_energy_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0d ns: %s expected %0d, got %0d",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0d ns: %s expected %b, got %b",
                               $time, name, exp, act));
        end
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    // ========================================
    // Reference model
    // ========================================
    // Sum over k of sigma_k * (h_k * scale + sum over j != k of sigma_j * J_kj)
    function automatic total_energy_t model_energy(input spin_vec_t spins, input hscale_t code);
        int                      total;
        int                      scale;
        int                      coup;
        int                      sig_k;
        int                      sig_j;
        logic signed [BIT_J-1:0] w;
        total = 0;
        case (code)
            5'd1, 5'd2, 5'd4, 5'd8, 5'd16: scale = int'(code);
            default:                       scale = 1;  // Any other code is unity
        endcase
        for (int k = 0; k < NUM_SPINS; k++) begin
            sig_k = spins[k] ? 1 : -1;
            coup  = int'(model_h[k]) * scale;
            for (int j = 0; j < NUM_SPINS; j++) begin
                if (j != k) begin
                    w     = model_row[k][j*BIT_J +: BIT_J];
                    sig_j = spins[j] ? 1 : -1;
                    coup += sig_j * int'(w);
                end
            end
            total += sig_k * coup;
        end
        return total_energy_t'(total);
    endfunction

    // Mix of zero, powers of two and arbitrary codes
    function automatic hscale_t pick_code(input int n);
        int pick;
        pick = {$random(seed)} % 5;
        if (n == 0) begin
            return '0;
        end else if ((n % 3) == 1) begin
            return hscale_t'($random(seed));
        end
        return hscale_t'(1 << pick);
    endfunction

    // ========================================
    // Stimulus tasks, entered and left at a falling edge
    // ========================================
    task automatic write_row(input spin_idx_t idx, input weight_row_t row, input hbias_t h);
        wr_en    = 1'b1;
        wr_idx   = idx;
        wr_row   = row;
        wr_hbias = h;
        @(negedge clk);            // Stored on the rising edge in between
        wr_en          = 1'b0;
        model_row[idx] = row;
        model_h[idx]   = h;
    endtask

    // One evaluation; restart_at > 0 pulses start again that many edges in
    task automatic run_eval(input spin_vec_t spins, input hscale_t code,
                            input total_energy_t exp, input int restart_at);
        int   edges;
        logic done_seen;
        start    = 1'b1;
        spin     = spins;
        hscaling = code;
        @(posedge clk);            // Start edge
        @(negedge clk);
        start = 1'b0;
        check_flag("busy_o", 1'b1, busy);
        check_flag("done_o", 1'b0, done);
        edges     = 0;
        done_seen = 1'b0;
        while (!done_seen && edges < DONE_LATENCY + 4) begin
            if (restart_at > 0 && edges == restart_at) begin
                start    = 1'b1;   // Must be ignored while busy
                spin     = spin_vec_t'($random(seed));
                hscaling = hscale_t'($random(seed));
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
            done_seen = done;
            if (!done_seen) begin
                check_flag("busy_o", 1'b1, busy);
            end
        end
        start = 1'b0;
        if (!done_seen) begin
            fail_run("done_o never rose after an accepted start");
        end else if (edges != DONE_LATENCY) begin
            fail_run($sformatf("done_o rose %0d edges after start instead of %0d",
                               edges, DONE_LATENCY));
        end
        check_flag("busy_o", 1'b0, busy);
        check_energy("energy_o", exp, energy);
        @(posedge clk);
        @(negedge clk);
        check_flag("done_o", 1'b0, done);      // Single pulse
        check_flag("busy_o", 1'b0, busy);      // No second run started
        check_energy("energy_o", exp, energy);  // Total held
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        spin_vec_t   spins_r;
        hscale_t     code_r;
        weight_row_t row_r;
        spin_idx_t   idx_r;
        seed     = 32'hd137;
        wr_en    = 1'b0;
        wr_idx   = '0;
        wr_row   = '0;
        wr_hbias = '0;
        start    = 1'b0;
        spin     = '0;
        hscaling = '0;
        for (int i = 0; i < NUM_SPINS; i++) begin
            model_row[i] = '0;     // Matches the cleared memory
            model_h[i]   = '0;
        end
        wait (arst_n === 1'b1);
        @(negedge clk);

        // Reset values, then a run on empty memory
        check_flag("busy_o", 1'b0, busy);
        check_flag("done_o", 1'b0, done);
        check_energy("energy_o", '0, energy);
        run_eval(spin_vec_t'($random(seed)), hscale_t'($random(seed)), '0, 0);

        // All weights +1, no field, all spins up
        for (int i = 0; i < NUM_SPINS; i++) begin
            write_row(spin_idx_t'(i), {NUM_SPINS{4'h1}}, '0);
        end
        run_eval('1, hscale_t'(1), total_energy_t'(NUM_SPINS * (NUM_SPINS - 1)), 0);

        // Random couplings and fields
        for (int i = 0; i < NUM_SPINS; i++) begin
            row_r = {$random(seed), $random(seed)};
            write_row(spin_idx_t'(i), row_r, hbias_t'($random(seed)));
        end
        for (int n = 0; n < RAND_EVALS; n++) begin
            spins_r = spin_vec_t'($random(seed));
            code_r  = pick_code(n);
            run_eval(spins_r, code_r, model_energy(spins_r, code_r), 0);
        end

        // Second start in mid run
        spins_r = spin_vec_t'($random(seed));
        code_r  = pick_code(2);
        run_eval(spins_r, code_r, model_energy(spins_r, code_r), 7);

        // Rewrite one row and field
        row_r = {$random(seed), $random(seed)};
        idx_r = spin_idx_t'($random(seed));
        write_row(idx_r, row_r, hbias_t'($random(seed)));
        spins_r = spin_vec_t'($random(seed));
        code_r  = hscale_t'(8);
        run_eval(spins_r, code_r, model_energy(spins_r, code_r), 0);

        // Every failure stops the run on the spot
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/ising_energy_pkg.sv
source/partial_energy_if.sv
source/adder_tree.sv
source/partial_energy_calc.sv
source/coupling_mem.sv
source/energy_sequencer.sv
source/ising_energy_top.sv
tests/tb_clock_gen.sv
tests/tb_ising_energy.sv

// File: Makefile
SIM := obj_dir/Vtb_ising_energy

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): verilog.f $(wildcard source/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ising_energy -Mdir obj_dir -f verilog.f

# Exit status of the simulation is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
